/* include/cube_defs.svh */
// Bus widths, raster timing and pixel clock ratio for the display subsystem.
`ifndef CUBE_DEFS_SVH
`define CUBE_DEFS_SVH

//////////////////////////////
// Bus widths.
//////////////////////////////

// Word address into the VRAM.
`define CUBE_ADDR_W 15
// One VRAM word holds one RGB565 pixel.
`define CUBE_DATA_W 16
`define CUBE_BYTE_W 8
// Output color, six bits per channel.
`define CUBE_RGB_W  18

//////////////////////////////
// Raster timing, in pixels and lines.
//////////////////////////////

`define CUBE_H_ACTIVE 16
`define CUBE_H_FRONT  2
`define CUBE_H_SYNC   4
`define CUBE_H_BACK   2
`define CUBE_H_TOTAL  (`CUBE_H_ACTIVE + `CUBE_H_FRONT + `CUBE_H_SYNC + `CUBE_H_BACK)

`define CUBE_V_ACTIVE 8
`define CUBE_V_FRONT  1
`define CUBE_V_SYNC   2
`define CUBE_V_BACK   1
`define CUBE_V_TOTAL  (`CUBE_V_ACTIVE + `CUBE_V_FRONT + `CUBE_V_SYNC + `CUBE_V_BACK)

// Clock cycles per pixel, also the length of one arbiter window.
`define CUBE_PIX_DIV 4

`endif

/* rtl/cube_pkg.sv */
// Shared struct types for the host bus, the VRAM controls and display fetches.
`include "cube_defs.svh"

package cube_pkg;

  //////////////////////////////
  // Host side.
  //////////////////////////////

  // Byte access from the SPI slave.
  // Rd and wr are one-cycle strobes.
  typedef struct packed {
    logic                     rd;
    logic                     wr;
    logic [`CUBE_ADDR_W:0]    addr;
    logic [`CUBE_BYTE_W-1:0]  wdata;
  } byte_acc_t;

  // Word request toward the arbiter.
  // Be is one bit per byte lane, bit 0 is the low byte.
  typedef struct packed {
    logic                     en;
    logic                     rd;
    logic                     wr;
    logic [1:0]               be;
    logic [`CUBE_ADDR_W-1:0]  addr;
    logic [`CUBE_DATA_W-1:0]  wdata;
  } mpu_req_t;

  //////////////////////////////
  // Memory and display side.
  //////////////////////////////

  // VRAM controls, all active high inside the chip.
  typedef struct packed {
    logic                     en;
    logic                     rd;
    logic                     wr;
    logic [1:0]               be;
    logic [`CUBE_ADDR_W-1:0]  addr;
    logic [`CUBE_DATA_W-1:0]  wdata;
  } vram_pins_t;

  // Pixel fetch, req pulses once per pixel.
  typedef struct packed {
    logic                     req;
    logic [`CUBE_ADDR_W-1:0]  addr;
  } disp_fetch_t;

endpackage

/* rtl/spi_mem_slave.sv */
// SPI mode-0 slave with address header, byte strobes and auto-increment.
`timescale 1ns/1ps
`include "cube_defs.svh"

module spi_mem_slave (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     spi_cs_n,
  input  logic                     sck,
  input  logic                     mosi,
  output logic                     miso,
  output cube_pkg::byte_acc_t      acc,
  input  logic [`CUBE_BYTE_W-1:0]  rdata,
  input  logic                     rd_valid
);

  // Byte address is one bit wider than the word address.
  localparam int BAW = `CUBE_ADDR_W + 1;

  logic [2:0]              sck_sync;
  logic [1:0]              mosi_sync;
  logic [1:0]              cs_sync;
  logic                    sck_rise;
  logic                    sck_fall;
  logic                    cs_active;
  logic [2:0]              bit_cnt;
  logic [1:0]              byte_idx;
  logic                    is_write;
  logic [7:0]              rx_sh;
  logic [7:0]              rx_next;
  logic [7:0]              hdr_hi;
  logic [7:0]              tx_sh;
  logic [BAW-1:0]          addr_cnt;
  logic [BAW-1:0]          start_addr;

  //////////////////////////////
  // Pin synchronizers.
  //////////////////////////////

  // Two flops per pin, sck keeps a third for edge detection.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync  <= '0;
      mosi_sync <= '0;
      cs_sync   <= '1;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      mosi_sync <= {mosi_sync[0], mosi};
      cs_sync   <= {cs_sync[0], spi_cs_n};
    end
  end

  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  assign cs_active = ~cs_sync[1];

  // Shift register value once the current bit is in, MSB first.
  assign rx_next    = {rx_sh[6:0], mosi_sync[1]};
  // Header bit 15 is the write flag, the rest is the byte address.
  assign start_addr = {1'b0, hdr_hi[6:0], rx_next};

  //////////////////////////////
  // Frame decoder.
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt  <= '0;
      byte_idx <= '0;
      is_write <= 1'b0;
      rx_sh    <= '0;
      hdr_hi   <= '0;
      tx_sh    <= '0;
      addr_cnt <= '0;
      miso     <= 1'b0;
      acc      <= '0;
    end else if (!cs_active) begin
      // Deselect ends the frame.
      bit_cnt  <= '0;
      byte_idx <= '0;
      is_write <= 1'b0;
      tx_sh    <= '0;
      miso     <= 1'b0;
      acc.rd   <= 1'b0;
      acc.wr   <= 1'b0;
    end else begin
      acc.rd <= 1'b0;
      acc.wr <= 1'b0;
      if (sck_rise) begin
        rx_sh   <= rx_next;
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          case (byte_idx)
            2'd0: begin
              hdr_hi   <= rx_next;
              byte_idx <= 2'd1;
            end
            2'd1: begin
              // Header done, a read frame fetches its first byte at once.
              is_write <= hdr_hi[7];
              byte_idx <= 2'd2;
              addr_cnt <= start_addr;
              if (!hdr_hi[7]) begin
                acc.rd   <= 1'b1;
                acc.addr <= start_addr;
                addr_cnt <= start_addr + 1'b1;
              end
            end
            default: begin
              // Data byte, write it or prefetch the next one.
              acc.addr <= addr_cnt;
              addr_cnt <= addr_cnt + 1'b1;
              if (is_write) begin
                acc.wr    <= 1'b1;
                acc.wdata <= rx_next;
              end else begin
                acc.rd <= 1'b1;
              end
            end
          endcase
        end
      end
      // Master samples on rising sck, so shift out on falling.
      if (sck_fall) begin
        miso  <= tx_sh[7];
        tx_sh <= {tx_sh[6:0], 1'b0};
      end
      if (rd_valid) begin
        tx_sh <= rdata;
      end
    end
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(acc.rd && acc.wr))
    else $error("spi slave issued rd and wr together");

endmodule

/* rtl/mpu_bus_bridge.sv */
// Byte to word bridge with byte-lane decode and read byte select.
`timescale 1ns/1ps
`include "cube_defs.svh"

module mpu_bus_bridge (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cube_pkg::byte_acc_t      acc,
  output cube_pkg::mpu_req_t       req,
  input  logic [`CUBE_DATA_W-1:0]  word_rdata,
  input  logic                     word_valid,
  output logic [`CUBE_BYTE_W-1:0]  rdata,
  output logic                     rd_valid
);

  // Lane of the access in flight, 1 is the high byte.
  logic lane_hi;
  // A read is waiting for its word.
  logic rd_pend;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req     <= '0;
      lane_hi <= 1'b0;
      rd_pend <= 1'b0;
    end else begin
      req.en <= acc.rd | acc.wr;
      req.rd <= acc.rd;
      req.wr <= acc.wr;
      if (acc.rd | acc.wr) begin
        // Odd byte address goes to the high lane.
        req.be    <= acc.addr[0] ? 2'b10 : 2'b01;
        req.addr  <= acc.addr[`CUBE_ADDR_W:1];
        // Byte copied to both lanes, be picks the one written.
        req.wdata <= {acc.wdata, acc.wdata};
        lane_hi   <= acc.addr[0];
      end
      if (acc.rd) begin
        rd_pend <= 1'b1;
      end else if (word_valid) begin
        rd_pend <= 1'b0;
      end
    end
  end

  // Returned byte, passed straight on to save a cycle.
  assign rdata    = lane_hi ? word_rdata[15:8] : word_rdata[7:0];
  assign rd_valid = word_valid & rd_pend;

  a_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    req.en |-> (req.be != 2'b00))
    else $error("bridge request without byte enable");

endmodule

/* rtl/vram_arbiter.sv */
// Time-slot VRAM arbiter for display fetches and host accesses.
`timescale 1ns/1ps
`include "cube_defs.svh"

module vram_arbiter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cube_pkg::mpu_req_t       host,
  output logic [`CUBE_DATA_W-1:0]  host_rdata,
  output logic                     host_valid,
  input  cube_pkg::disp_fetch_t    fetch,
  output logic [`CUBE_DATA_W-1:0]  pix_data,
  output logic                     pix_valid,
  output cube_pkg::vram_pins_t     pins,
  input  logic [`CUBE_DATA_W-1:0]  vram_rdata
);

  localparam int SLOT_W = $clog2(`CUBE_PIX_DIV);
  localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(`CUBE_PIX_DIV - 1);

  logic [SLOT_W-1:0]       slot;
  logic                    host_pend;
  logic                    h_go;
  logic                    h_stb;
  logic                    fetch_pend;
  logic                    disp_win;
  logic                    d_go;
  logic                    d_stb;
  logic [`CUBE_ADDR_W-1:0] fetch_addr;
  logic [`CUBE_ADDR_W-1:0] disp_addr;
  cube_pkg::mpu_req_t      hq;
  cube_pkg::mpu_req_t      cur;

  // A request can start in the cycle it shows up.
  assign cur   = host.en ? host : hq;
  // Display owns slots 0 and 1 of a window it was granted.
  assign d_go  = disp_win && (slot == '0);
  assign d_stb = disp_win && (slot == SLOT_W'(1));
  // Host starts on even slots only, so its strobe never crosses a window.
  assign h_go  = (host.en || host_pend) && !slot[0] && !d_go;

  //////////////////////////////
  // Slot and grant state.
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot       <= '0;
      host_pend  <= 1'b0;
      h_stb      <= 1'b0;
      fetch_pend <= 1'b0;
      disp_win   <= 1'b0;
      host_valid <= 1'b0;
      pix_valid  <= 1'b0;
    end else begin
      slot  <= (slot == SLOT_LAST) ? '0 : slot + 1'b1;
      h_stb <= h_go;
      if (h_go) begin
        host_pend <= 1'b0;
      end else if (host.en) begin
        host_pend <= 1'b1;
      end
      // Grant the next window to a fetch seen in this one.
      if (slot == SLOT_LAST) begin
        disp_win   <= fetch_pend | fetch.req;
        fetch_pend <= 1'b0;
      end else if (fetch.req) begin
        fetch_pend <= 1'b1;
      end
      host_valid <= h_stb;
      pix_valid  <= d_stb;
    end
  end

  // Request payload and read data.
  always_ff @(posedge clk) begin
    if (host.en) begin
      hq <= host;
    end
    if (fetch.req) begin
      fetch_addr <= fetch.addr;
    end
    if (slot == SLOT_LAST) begin
      disp_addr <= fetch.req ? fetch.addr : fetch_addr;
    end
    // SRAM data is sampled at the end of the strobe cycle.
    if (h_stb) begin
      host_rdata <= vram_rdata;
    end
    if (d_stb) begin
      pix_data <= vram_rdata;
    end
  end

  //////////////////////////////
  // Pin drive.
  //////////////////////////////

  always_comb begin
    pins = '0;
    if (d_go || d_stb) begin
      // Full-word display read.
      pins.en   = 1'b1;
      pins.rd   = d_stb;
      pins.be   = 2'b11;
      pins.addr = disp_addr;
    end else if (h_go) begin
      // Address setup, no strobe yet.
      pins.en    = 1'b1;
      pins.be    = cur.be;
      pins.addr  = cur.addr;
      pins.wdata = cur.wdata;
    end else if (h_stb) begin
      pins.en    = 1'b1;
      pins.rd    = hq.rd;
      pins.wr    = hq.wr;
      pins.be    = hq.be;
      pins.addr  = hq.addr;
      pins.wdata = hq.wdata;
    end
  end

  // A host write strobe never lands in a display slot.
  a_no_wr_disp: assert property (@(posedge clk) disable iff (!rst_n)
    (d_go || d_stb) |-> !(h_stb && hq.wr))
    else $error("write during a display slot");

  a_one_host: assert property (@(posedge clk) disable iff (!rst_n)
    host.en |-> !(host_pend || h_stb))
    else $error("host request while another is pending");

endmodule

/* rtl/vga_scanout.sv */
// Raster counters, sync, pixel fetch addressing and RGB565 to RGB666 output.
`timescale 1ns/1ps
`include "cube_defs.svh"

module vga_scanout (
  input  logic                     clk,
  input  logic                     rst_n,
  output cube_pkg::disp_fetch_t    fetch,
  input  logic [`CUBE_DATA_W-1:0]  pix_data,
  input  logic                     pix_valid,
  output logic                     hsync,
  output logic                     vsync,
  output logic [`CUBE_RGB_W-1:0]   rgb
);

  localparam int AW     = `CUBE_ADDR_W;
  localparam int H_TOT  = `CUBE_H_TOTAL;
  localparam int V_TOT  = `CUBE_V_TOTAL;
  localparam int H_SS   = `CUBE_H_ACTIVE + `CUBE_H_FRONT;
  localparam int H_SE   = H_SS + `CUBE_H_SYNC;
  localparam int V_SS   = `CUBE_V_ACTIVE + `CUBE_V_FRONT;
  localparam int V_SE   = V_SS + `CUBE_V_SYNC;
  localparam int DIV_W  = $clog2(`CUBE_PIX_DIV);
  localparam int H_W    = $clog2(H_TOT);
  localparam int V_W    = $clog2(V_TOT);

  logic [DIV_W-1:0]        div;
  logic                    pix_end;
  logic [H_W-1:0]          hcnt;
  logic [V_W-1:0]          vcnt;
  logic [H_W-1:0]          h_n;
  logic [V_W-1:0]          v_n;
  logic [V_W-1:0]          v_inc;
  logic [H_W-1:0]          h_t;
  logic [V_W-1:0]          v_t;
  logic [`CUBE_DATA_W-1:0] pix_buf;
  logic [`CUBE_RGB_W-1:0]  rgb_next;

  assign pix_end = (div == DIV_W'(`CUBE_PIX_DIV - 1));

  // Raster position of the next pixel period.
  assign v_inc = (vcnt == V_W'(V_TOT - 1)) ? '0 : vcnt + 1'b1;
  assign h_n   = (hcnt == H_W'(H_TOT - 1)) ? '0 : hcnt + 1'b1;
  assign v_n   = (hcnt == H_W'(H_TOT - 1)) ? v_inc : vcnt;

  //////////////////////////////
  // Fetch addressing.
  //////////////////////////////

  // Target is two periods on: the next one is the fetch window,
  // the one after shows the pixel.
  always_comb begin
    if (hcnt >= H_W'(H_TOT - 2)) begin
      h_t = hcnt - H_W'(H_TOT - 2);
      v_t = v_inc;
    end else begin
      h_t = hcnt + H_W'(2);
      v_t = vcnt;
    end
  end

  // Pulse in the last cycle of the period, as the arbiter window closes.
  assign fetch.req  = pix_end && (h_t < `CUBE_H_ACTIVE) && (v_t < `CUBE_V_ACTIVE);
  assign fetch.addr = AW'(v_t) * AW'(`CUBE_H_ACTIVE) + AW'(h_t);

  // Repeat the top bit of red and blue, green is already six bits.
  assign rgb_next = {pix_buf[15:11], pix_buf[15], pix_buf[10:5],
                     pix_buf[4:0], pix_buf[4]};

  always_ff @(posedge clk) begin
    if (pix_valid) begin
      pix_buf <= pix_data;
    end
  end

  //////////////////////////////
  // Counters and outputs.
  //////////////////////////////

  // Reset lands two pixels before the frame so its first fetch is in time.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div   <= '0;
      hcnt  <= H_W'(H_TOT - 2);
      vcnt  <= V_W'(V_TOT - 1);
      hsync <= 1'b1;
      vsync <= 1'b1;
      rgb   <= '0;
    end else begin
      div <= pix_end ? '0 : div + 1'b1;
      if (pix_end) begin
        hcnt  <= h_n;
        vcnt  <= v_n;
        // Sync low only inside its window.
        hsync <= !((h_n >= H_SS) && (h_n < H_SE));
        vsync <= !((v_n >= V_SS) && (v_n < V_SE));
        rgb   <= ((h_n < `CUBE_H_ACTIVE) && (v_n < `CUBE_V_ACTIVE)) ? rgb_next : '0;
      end
    end
  end

endmodule

/* rtl/cube_top.sv */
// Top level with SPI slave, bridge, VRAM arbiter, scan-out and pin adaption.
`timescale 1ns/1ps
`include "cube_defs.svh"

module cube_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     spi_cs_n,
  input  logic                     sck,
  input  logic                     mosi,
  output logic                     miso,
  output logic                     vram_en_n,
  output logic                     vram_rd_n,
  output logic                     vram_wr_n,
  output logic [1:0]               vram_be_n,
  output logic [`CUBE_ADDR_W-1:0]  vram_addr,
  inout  wire  [`CUBE_DATA_W-1:0]  vram_data,
  output logic                     hsync,
  output logic                     vsync,
  output logic [`CUBE_RGB_W-1:0]   rgb
);

  cube_pkg::byte_acc_t     acc;
  cube_pkg::mpu_req_t      req;
  cube_pkg::disp_fetch_t   fetch;
  cube_pkg::vram_pins_t    pins;
  logic [`CUBE_BYTE_W-1:0] byte_rdata;
  logic                    byte_valid;
  logic [`CUBE_DATA_W-1:0] word_rdata;
  logic                    word_valid;
  logic [`CUBE_DATA_W-1:0] pix_data;
  logic                    pix_valid;
  logic [`CUBE_DATA_W-1:0] vram_rdata;

  //////////////////////////////
  // Host path.
  //////////////////////////////

  spi_mem_slave u_spi (
    .clk      (clk),
    .rst_n    (rst_n),
    .spi_cs_n (spi_cs_n),
    .sck      (sck),
    .mosi     (mosi),
    .miso     (miso),
    .acc      (acc),
    .rdata    (byte_rdata),
    .rd_valid (byte_valid)
  );

  mpu_bus_bridge u_bridge (
    .clk        (clk),
    .rst_n      (rst_n),
    .acc        (acc),
    .req        (req),
    .word_rdata (word_rdata),
    .word_valid (word_valid),
    .rdata      (byte_rdata),
    .rd_valid   (byte_valid)
  );

  vram_arbiter u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .host       (req),
    .host_rdata (word_rdata),
    .host_valid (word_valid),
    .fetch      (fetch),
    .pix_data   (pix_data),
    .pix_valid  (pix_valid),
    .pins       (pins),
    .vram_rdata (vram_rdata)
  );

  // Display side.
  vga_scanout u_scan (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch     (fetch),
    .pix_data  (pix_data),
    .pix_valid (pix_valid),
    .hsync     (hsync),
    .vsync     (vsync),
    .rgb       (rgb)
  );

  //////////////////////////////
  // VRAM pins.
  //////////////////////////////

  // Board side controls are active low.
  assign vram_en_n = ~pins.en;
  assign vram_rd_n = ~pins.rd;
  assign vram_wr_n = ~pins.wr;
  assign vram_be_n = ~pins.be;
  assign vram_addr = pins.addr;

  // Bus driven only while a write strobe is out.
  assign vram_data  = (pins.en & pins.wr) ? pins.wdata : {`CUBE_DATA_W{1'bz}};
  assign vram_rdata = vram_data;

endmodule

/* sim/vram_model.sv */
// Asynchronous SRAM model with byte enables, preload and peek access.
`timescale 1ns/1ps
`include "cube_defs.svh"

module vram_model (
  input  logic                     en_n,
  input  logic                     rd_n,
  input  logic                     wr_n,
  input  logic [1:0]               be_n,
  input  logic [`CUBE_ADDR_W-1:0]  addr,
  inout  wire  [`CUBE_DATA_W-1:0]  data
);

  localparam int DEPTH = 1 << `CUBE_ADDR_W;

  logic [`CUBE_DATA_W-1:0] mem [0:DEPTH-1];

  // Power-up content, a different word at every address.
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i[`CUBE_ADDR_W-1:0]] = 16'(i) ^ 16'hC3A5;
    end
  end

  // Output enabled by a read strobe with no write pending.
  assign data = (!en_n && !rd_n && wr_n) ? mem[addr] : {`CUBE_DATA_W{1'bz}};

  // Write lands 1 ns into the strobe, once address and data have settled.
  always @(negedge wr_n) begin
    #1;
    if (!en_n) begin
      if (!be_n[0]) mem[addr][7:0] = data[7:0];
      if (!be_n[1]) mem[addr][15:8] = data[15:8];
    end
  end

  // Direct backdoor access.
  task automatic preload(input logic [`CUBE_ADDR_W-1:0] a, input logic [15:0] d);
    mem[a] = d;
  endtask

  function automatic logic [15:0] peek(input logic [`CUBE_ADDR_W-1:0] a);
    return mem[a];
  endfunction

endmodule

/* sim/tb_cube_top.sv */
// Testbench for cube_top with SPI driver, VRAM model, reference functions and checks.
`timescale 1ns/1ps
`include "cube_defs.svh"

module tb_cube_top;

  // Sck half period in clk cycles.
  localparam int HALF      = 10;
  localparam int LINE_CYC  = `CUBE_H_TOTAL * `CUBE_PIX_DIV;
  localparam int FRAME_CYC = LINE_CYC * `CUBE_V_TOTAL;
  // Under 30 SPI frames of up to 10 bytes at 160 cycles each, plus 3 display frames.
  localparam int TIMEOUT_CYC = 60000;

  logic                    clk;
  logic                    rst_n;
  logic                    spi_cs_n;
  logic                    sck;
  logic                    mosi;
  logic                    miso;
  logic                    vram_en_n;
  logic                    vram_rd_n;
  logic                    vram_wr_n;
  logic [1:0]              vram_be_n;
  logic [`CUBE_ADDR_W-1:0] vram_addr;
  wire  [`CUBE_DATA_W-1:0] vram_data;
  logic                    hsync;
  logic                    vsync;
  logic [`CUBE_RGB_W-1:0]  rgb;

  // Scoreboard of written bytes, indexed by byte address.
  logic [7:0]  sb [0:65535];
  logic [7:0]  tx_buf [0:15];
  logic [7:0]  rx_buf [0:15];
  logic [15:0] pix_words [0:127];
  int          cycle;
  int          err_cnt;
  int          chk_cnt;
  int          test_base;

  cube_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .spi_cs_n  (spi_cs_n),
    .sck       (sck),
    .mosi      (mosi),
    .miso      (miso),
    .vram_en_n (vram_en_n),
    .vram_rd_n (vram_rd_n),
    .vram_wr_n (vram_wr_n),
    .vram_be_n (vram_be_n),
    .vram_addr (vram_addr),
    .vram_data (vram_data),
    .hsync     (hsync),
    .vsync     (vsync),
    .rgb       (rgb)
  );

  vram_model u_mem (
    .en_n (vram_en_n),
    .rd_n (vram_rd_n),
    .wr_n (vram_wr_n),
    .be_n (vram_be_n),
    .addr (vram_addr),
    .data (vram_data)
  );

  always #10 clk = ~clk;

  // Cycle count and run limit.
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYC) begin
      $display("run timed out after %0d cycles", cycle);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Reference functions.
  //////////////////////////////

  // RGB565 to RGB666, red and blue repeat their top bit.
  function automatic logic [17:0] expand_rgb(input logic [15:0] w);
    logic [5:0] r6;
    logic [5:0] g6;
    logic [5:0] b6;
    r6 = {w[15:11], w[15]};
    g6 = w[10:5];
    b6 = {w[4:0], w[4]};
    return {r6, g6, b6};
  endfunction

  function automatic int word_index(input int x, input int y);
    return y * `CUBE_H_ACTIVE + x;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, err_cnt - test_base);
    test_base = err_cnt;
  endtask

  //////////////////////////////
  // SPI driver.
  //////////////////////////////

  // Mode 0, data changes with sck low and is sampled on the rising edge.
  // Called on a rising clk edge.
  task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      mosi <= tx[i];
      repeat (HALF) @(posedge clk);
      sck   <= 1'b1;
      rx[i] = miso;
      repeat (HALF) @(posedge clk);
      sck <= 1'b0;
    end
  endtask

  // Header with write flag, then len data bytes.
  task automatic run_frame(input logic is_wr, input logic [15:0] addr, input int len);
    logic [7:0] rx;
    @(posedge clk);
    spi_cs_n <= 1'b0;
    repeat (HALF) @(posedge clk);
    shift_byte({is_wr, addr[14:8]}, rx);
    shift_byte(addr[7:0], rx);
    for (int k = 0; k < len; k++) begin
      shift_byte(is_wr ? tx_buf[k] : 8'h00, rx);
      rx_buf[k] = rx;
    end
    repeat (HALF) @(posedge clk);
    spi_cs_n <= 1'b1;
    repeat (2 * HALF) @(posedge clk);
  endtask

  task automatic spi_write(input logic [15:0] addr, input int len);
    for (int k = 0; k < len; k++) begin
      sb[addr + 16'(k)] = tx_buf[k];
    end
    run_frame(1'b1, addr, len);
  endtask

  task automatic spi_read(input logic [15:0] addr, input int len);
    run_frame(1'b0, addr, len);
  endtask

  // Random burst written and read back against the scoreboard.
  task automatic write_read_random(input int base);
    logic [15:0] a;
    int          len;
    a   = 16'(base + int'($urandom % 512));
    len = 1 + int'($urandom % 8);
    for (int k = 0; k < len; k++) begin
      tx_buf[k] = 8'($urandom);
    end
    spi_write(a, len);
    spi_read(a, len);
    for (int k = 0; k < len; k++) begin
      compare_value("miso byte", sb[a + 16'(k)], rx_buf[k]);
    end
  endtask

  //////////////////////////////
  // Display checks.
  //////////////////////////////

  // Waits for a falling sync edge, sampled on the falling clk edge.
  task automatic wait_sync_fall(input bit use_v, output int at);
    logic prev;
    logic cur;
    cur = use_v ? vsync : hsync;
    do begin
      prev = cur;
      @(negedge clk);
      cur = use_v ? vsync : hsync;
    end while (!(prev === 1'b1 && cur === 1'b0));
    at = cycle;
  endtask

  // Vsync falls as line 9 starts; each pixel is shown in its own period.
  task automatic check_frame();
    int          t;
    int          h;
    int          v;
    logic [17:0] exp;
    wait_sync_fall(1'b1, t);
    for (int c = 0; c < FRAME_CYC; c++) begin
      h = (c % LINE_CYC) / `CUBE_PIX_DIV;
      v = (`CUBE_V_ACTIVE + `CUBE_V_FRONT + c / LINE_CYC) % `CUBE_V_TOTAL;
      if (h < `CUBE_H_ACTIVE && v < `CUBE_V_ACTIVE) begin
        exp = expand_rgb(pix_words[word_index(h, v)]);
      end else begin
        exp = '0;
      end
      compare_value("rgb", exp, rgb);
      @(negedge clk);
    end
  endtask

  //////////////////////////////
  // Test sequence.
  //////////////////////////////

  initial begin
    logic [15:0] a;
    logic [15:0] old_w;
    int          lane;
    int          t0;
    int          t1;
    void'($urandom(55912));
    clk       = 1'b0;
    rst_n     = 1'b0;
    spi_cs_n  = 1'b1;
    sck       = 1'b0;
    mosi      = 1'b0;
    cycle     = 0;
    err_cnt   = 0;
    chk_cnt   = 0;
    test_base = 0;

    // Idle pins while reset is held.
    repeat (4) @(posedge clk);
    @(negedge clk);
    compare_value("vram_en_n", 1, vram_en_n);
    compare_value("vram_rd_n", 1, vram_rd_n);
    compare_value("vram_wr_n", 1, vram_wr_n);
    compare_value("vram_be_n", 2'b11, vram_be_n);
    compare_value("hsync", 1, hsync);
    compare_value("vsync", 1, vsync);
    compare_value("rgb", 0, rgb);
    compare_value("miso", 0, miso);
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    report_test("reset state");

    // One byte per lane, the other lane of the word must keep its value.
    for (int n = 0; n < 2; n++) begin
      a         = 16'h0300 + 16'(n * 3);
      lane      = int'(a[0]);
      old_w     = u_mem.peek(a[15:1]);
      tx_buf[0] = 8'($urandom);
      spi_write(a, 1);
      spi_read({a[15:1], 1'b0}, 2);
      compare_value("miso byte", tx_buf[0], rx_buf[lane]);
      compare_value("miso other lane", lane ? old_w[7:0] : old_w[15:8], rx_buf[1 - lane]);
    end
    report_test("byte lanes");

    for (int n = 0; n < 8; n++) begin
      write_read_random(16'h0400);
    end
    report_test("auto-increment bursts");

    wait_sync_fall(1'b0, t0);
    wait_sync_fall(1'b0, t1);
    compare_value("hsync period", LINE_CYC, t1 - t0);
    wait_sync_fall(1'b1, t0);
    wait_sync_fall(1'b1, t1);
    compare_value("vsync period", FRAME_CYC, t1 - t0);
    report_test("sync timing");

    // Frame buffer content, then host traffic during scan-out.
    for (int n = 0; n < 128; n++) begin
      pix_words[n] = 16'($urandom);
      u_mem.preload(15'(n), pix_words[n]);
    end
    fork
      check_frame();
      begin
        for (int n = 0; n < 4; n++) begin
          write_read_random(16'h0600);
        end
      end
    join
    report_test("pixel output with host traffic");

    $display("checks passed %0d, failed %0d", chk_cnt - err_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+include
rtl/cube_pkg.sv
rtl/spi_mem_slave.sv
rtl/mpu_bus_bridge.sv
rtl/vram_arbiter.sv
rtl/vga_scanout.sv
rtl/cube_top.sv
sim/vram_model.sv
sim/tb_cube_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_cube_top
FILELIST  := list.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
LOG       := sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@! grep -q "Test FAILED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
